// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    // ==================================================================
    // Basic types
    // ==================================================================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

    localparam word_t RESET_PC = 32'hbfc0_0000;  // Boot ROM vector

    // ==================================================================
    // Opcode and funct encodings
    // ==================================================================
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // ==================================================================
    // Stage payloads
    // ==================================================================
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_data_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        alu_op_t    alu_op;
        word_t      srca;
        word_t      srcb;
        creg_addr_t dst;
        logic       we;
    } decode_data_t;

    typedef struct packed {
        logic       we;
        creg_addr_t addr;
        word_t      data;
    } rf_w_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        rf_w_t rfw;
    } exec_data_t;

    typedef rf_w_t bypass_upd_t;  // Counts only with we and addr != 0

endpackage

`default_nettype wire

// File: reg_read_if.sv
`timescale 1ns/1ns
`default_nettype none

interface reg_read_if import mips_pkg::*; ();

    creg_addr_t raddr1;
    creg_addr_t raddr2;
    word_t      rdata1;
    word_t      rdata2;

    modport requester (output raddr1, output raddr2, input rdata1, input rdata2);
    modport responder (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

`default_nettype wire

// File: fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch import mips_pkg::*; #(
    parameter word_t RESET_PC_P = RESET_PC
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        ihit,
    input  word_t       idata,
    output word_t       iaddr,
    output fetch_data_t out
);

    word_t pc;
    logic  take;

    assign take = ihit & ~stall;  // Word accepted this cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC_P;
        end else if (take) begin
            pc <= pc + 32'd4;
        end
    end

    assign iaddr = pc;

    always_comb begin
        out.valid = take;
        out.pc    = pc;
        out.instr = idata;
    end

endmodule

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  payload_t in,
    output payload_t out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;  // Clears valid with the rest
        end else if (!stall) begin
            out <= in;
        end
    end

endmodule

`default_nettype wire

// File: decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode import mips_pkg::*; (
    input  fetch_data_t  in,
    output creg_addr_t   src1,
    output creg_addr_t   src2,
    input  word_t        opa,
    input  word_t        opb,
    output decode_data_t out
);

    logic [5:0]  opcode;
    creg_addr_t  rs;
    creg_addr_t  rt;
    creg_addr_t  rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] imm;

    alu_op_t op;
    logic    known;
    logic    is_shift;
    logic    use_imm;
    logic    sign_ext;
    logic    dst_rd;
    word_t   imm_ext;

    assign opcode = in.instr[31:26];
    assign rs     = in.instr[25:21];
    assign rt     = in.instr[20:16];
    assign rd     = in.instr[15:11];
    assign shamt  = in.instr[10:6];
    assign funct  = in.instr[5:0];
    assign imm    = in.instr[15:0];

    assign src1 = rs;
    assign src2 = rt;

    // ==================================================================
    // Format and operation select
    // ==================================================================
    always_comb begin
        op       = ALU_ADD;
        known    = 1'b1;
        is_shift = 1'b0;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        dst_rd   = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dst_rd  = 1'b1;
                case (funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_NOR:  op = ALU_NOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_SLL: begin
                        op       = ALU_SLL;
                        is_shift = 1'b1;
                    end
                    FN_SRL: begin
                        op       = ALU_SRL;
                        is_shift = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                op       = ALU_ADD;
                sign_ext = 1'b1;
            end
            OP_SLTI: begin
                op       = ALU_SLT;
                sign_ext = 1'b1;
            end
            OP_ANDI: op = ALU_AND;
            OP_ORI:  op = ALU_OR;
            OP_XORI: op = ALU_XOR;
            OP_LUI:  op = ALU_LUI;
            default: known = 1'b0;  // Retires as NOP
        endcase
    end

    assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    always_comb begin
        out.valid  = in.valid;
        out.pc     = in.pc;
        out.alu_op = op;
        out.srca   = is_shift ? {27'd0, shamt} : opa;
        out.srcb   = use_imm ? imm_ext : opb;
        out.dst    = dst_rd ? rd : rt;
        out.we     = known;
    end

endmodule

`default_nettype wire

// File: bypass.sv
`timescale 1ns/1ns
`default_nettype none

module bypass import mips_pkg::*; (
    input  creg_addr_t  src1,
    input  creg_addr_t  src2,
    output word_t       opa,
    output word_t       opb,
    input  bypass_upd_t exec_upd,
    input  bypass_upd_t retire_upd,
    reg_read_if.requester rd
);

    function automatic logic hits(bypass_upd_t upd, creg_addr_t src);
        return upd.we && (upd.addr != '0) && (upd.addr == src);
    endfunction

    // Execute is the younger write, so it wins over retire
    function automatic word_t resolve(
        creg_addr_t  src,
        bypass_upd_t e_upd,
        bypass_upd_t r_upd,
        word_t       rf_data
    );
        word_t val;
        if (hits(e_upd, src)) begin
            val = e_upd.data;
        end else if (hits(r_upd, src)) begin
            val = r_upd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rd.raddr1 = src1;
    assign rd.raddr2 = src2;

    assign opa = resolve(src1, exec_upd, retire_upd, rd.rdata1);
    assign opb = resolve(src2, exec_upd, retire_upd, rd.rdata2);

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute import mips_pkg::*; (
    input  decode_data_t in,
    output exec_data_t   out
);

    word_t result;

    // ==================================================================
    // ALU
    // ==================================================================
    always_comb begin
        case (in.alu_op)
            ALU_ADD:  result = in.srca + in.srcb;
            ALU_SUB:  result = in.srca - in.srcb;
            ALU_AND:  result = in.srca & in.srcb;
            ALU_OR:   result = in.srca | in.srcb;
            ALU_XOR:  result = in.srca ^ in.srcb;
            ALU_NOR:  result = ~(in.srca | in.srcb);
            ALU_SLT:  result = {31'd0, $signed(in.srca) < $signed(in.srcb)};
            ALU_SLTU: result = {31'd0, in.srca < in.srcb};
            ALU_SLL:  result = in.srcb << in.srca[4:0];  // srca holds shamt
            ALU_SRL:  result = in.srcb >> in.srca[4:0];
            ALU_LUI:  result = {in.srcb[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    always_comb begin
        out.valid    = in.valid;
        out.pc       = in.pc;
        out.rfw.we   = in.valid & in.we & (in.dst != '0);
        out.rfw.addr = in.dst;
        out.rfw.data = result;
    end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  rf_w_t w,
    reg_read_if.responder rd
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w.we && (w.addr != '0)) begin
            regs[w.addr] <= w.data;
        end
    end

    // $zero is hardwired
    assign rd.rdata1 = (rd.raddr1 == '0) ? '0 : regs[rd.raddr1];
    assign rd.rdata2 = (rd.raddr2 == '0) ? '0 : regs[rd.raddr2];

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  freeze,
    input  logic  ihit,
    input  word_t idata,
    output word_t iaddr,
    output rf_w_t rfw,
    output word_t rt_pc,
    output logic  rt_valid
);

    fetch_data_t  fetch_out;
    fetch_data_t  dreg_out;
    decode_data_t dec_out;
    decode_data_t ereg_out;
    exec_data_t   exe_out;
    exec_data_t   rreg_out;

    creg_addr_t src1;
    creg_addr_t src2;
    word_t      opa;
    word_t      opb;

    reg_read_if rd_if ();

    // ==================================================================
    // Front end
    // ==================================================================
    fetch #(.RESET_PC_P(RESET_PC)) fetch (
        .clk(clk), .rst(rst), .stall(freeze),
        .ihit(ihit), .idata(idata), .iaddr(iaddr), .out(fetch_out)
    );

    stage_reg #(.payload_t(fetch_data_t)) dreg (
        .clk(clk), .rst(rst), .stall(freeze), .in(fetch_out), .out(dreg_out)
    );

    decode decode (
        .in(dreg_out), .src1(src1), .src2(src2), .opa(opa), .opb(opb), .out(dec_out)
    );

    bypass bypass (
        .src1(src1), .src2(src2), .opa(opa), .opb(opb),
        .exec_upd(exe_out.rfw), .retire_upd(rreg_out.rfw), .rd(rd_if.requester)
    );

    // ==================================================================
    // Back end
    // ==================================================================
    stage_reg #(.payload_t(decode_data_t)) ereg (
        .clk(clk), .rst(rst), .stall(freeze), .in(dec_out), .out(ereg_out)
    );

    execute execute (.in(ereg_out), .out(exe_out));

    stage_reg #(.payload_t(exec_data_t)) rreg (
        .clk(clk), .rst(rst), .stall(freeze), .in(exe_out), .out(rreg_out)
    );

    regfile regfile (.clk(clk), .rst(rst), .w(rreg_out.rfw), .rd(rd_if.responder));

    assign rfw      = rreg_out.rfw;
    assign rt_pc    = rreg_out.pc;
    assign rt_valid = rreg_out.valid;

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;  // Released on the third rising edge
    end

endmodule

`default_nettype wire

// File: datapath_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_assertions import mips_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  freeze,
    input logic  rt_valid,
    input word_t rt_pc,
    input rf_w_t rfw
);

    freeze_holds_retire: assert property (
        @(posedge clk) disable iff (rst) freeze |=> ($stable(rt_pc) && $stable(rt_valid))
    ) else $error("retire stage moved while frozen");

    write_needs_valid: assert property (
        @(posedge clk) disable iff (rst) rfw.we |-> rt_valid
    ) else $error("register write without rt_valid");

    no_zero_write: assert property (
        @(posedge clk) disable iff (rst) rfw.we |-> (rfw.addr != '0)
    ) else $error("register write aimed at register 0");

endmodule

`default_nettype wire

// File: datapath_tb.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_tb import mips_pkg::*; ();

    localparam int N_CYCLES  = 2000;  // About 1300 retirements at 3/4 hit and 7/8 unfrozen
    localparam int MAX_INSTR = N_CYCLES + 8;
    localparam int MIN_RET   = N_CYCLES / 2;

    logic  clk;
    logic  rst;
    logic  freeze;
    logic  ihit;
    word_t idata;
    word_t iaddr;
    rf_w_t rfw;
    word_t rt_pc;
    logic  rt_valid;

    word_t      imem [256];
    word_t      exp_pc [MAX_INSTR];
    logic       exp_we [MAX_INSTR];
    creg_addr_t exp_addr [MAX_INSTR];
    word_t      exp_data [MAX_INSTR];

    int acc = 0;        // Fetches accepted
    int ret = 0;        // Instructions retired
    int cyc = 0;
    int first_acc = 0;

    tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(3)) clock_i (.clk(clk), .rst(rst));

    datapath dut_i (
        .clk(clk), .rst(rst), .freeze(freeze), .ihit(ihit), .idata(idata),
        .iaddr(iaddr), .rfw(rfw), .rt_pc(rt_pc), .rt_valid(rt_valid)
    );

    bind datapath datapath_assertions assertions_i (
        .clk(clk), .rst(rst), .freeze(freeze), .rt_valid(rt_valid), .rt_pc(rt_pc), .rfw(rfw)
    );

    assign idata = imem[iaddr[9:2]];  // Program wraps every 1 KiB

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_error(input string what, input word_t got, input word_t exp);
        abort_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // ==================================================================
    // Program generation and reference model
    // ==================================================================
    function automatic creg_addr_t pick_reg();
        if ($urandom % 8 != 0) begin
            return creg_addr_t'($urandom % 8);  // Dense dependencies
        end
        return creg_addr_t'($urandom % 32);
    endfunction

    function automatic word_t gen_instr();
        int unsigned kind;
        logic [5:0]  fn;
        logic [5:0]  opc;
        kind = $urandom % 18;
        fn   = FN_ADDU;
        opc  = OP_ADDIU;
        case (kind)
            0: fn = FN_ADDU;
            1: fn = FN_SUBU;
            2: fn = FN_AND;
            3: fn = FN_OR;
            4: fn = FN_XOR;
            5: fn = FN_NOR;
            6: fn = FN_SLT;
            7: fn = FN_SLTU;
            8: fn = FN_SLL;
            9: fn = FN_SRL;
            10: opc = OP_ADDIU;
            11: opc = OP_SLTI;
            12: opc = OP_ANDI;
            13: opc = OP_ORI;
            14: opc = OP_XORI;
            15: opc = OP_LUI;
            16: opc = 6'h23;      // LW
            default: fn = 6'h18;  // MULT
        endcase
        if (kind < 10 || kind == 17) begin
            return {OP_SPECIAL, pick_reg(), pick_reg(), pick_reg(), 5'($urandom % 32), fn};
        end
        return {opc, pick_reg(), pick_reg(), 16'($urandom)};
    endfunction

    // a is the rs value, b the rt value
    task automatic model_instr(
        input  word_t      instr,
        input  word_t      a,
        input  word_t      b,
        output logic       we,
        output creg_addr_t dst,
        output word_t      val
    );
        word_t sext;
        word_t zext;
        sext = {{16{instr[15]}}, instr[15:0]};
        zext = {16'h0000, instr[15:0]};
        we   = 1'b1;
        dst  = instr[20:16];
        val  = '0;
        if (instr[31:26] == OP_SPECIAL) begin
            dst = instr[15:11];
            case (instr[5:0])
                FN_ADDU: val = a + b;
                FN_SUBU: val = a - b;
                FN_AND:  val = a & b;
                FN_OR:   val = a | b;
                FN_XOR:  val = a ^ b;
                FN_NOR:  val = ~(a | b);
                FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                FN_SLL:  val = b << instr[10:6];
                FN_SRL:  val = b >> instr[10:6];
                default: we = 1'b0;
            endcase
        end else begin
            case (instr[31:26])
                OP_ADDIU: val = a + sext;
                OP_SLTI:  val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OP_ANDI:  val = a & zext;
                OP_ORI:   val = a | zext;
                OP_XORI:  val = a ^ zext;
                OP_LUI:   val = {instr[15:0], 16'h0000};
                default:  we = 1'b0;
            endcase
        end
        if (dst == '0) begin
            we = 1'b0;
        end
    endtask

    task automatic build_program();
        word_t      regs [32];
        word_t      pc;
        word_t      instr;
        logic       we;
        creg_addr_t dst;
        word_t      val;
        for (int i = 0; i < 256; i++) begin
            imem[i] = gen_instr();
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = RESET_PC;
        for (int n = 0; n < MAX_INSTR; n++) begin
            instr = imem[pc[9:2]];
            model_instr(instr, regs[instr[25:21]], regs[instr[20:16]], we, dst, val);
            if (we) begin
                regs[dst] = val;
            end
            exp_pc[n]   = pc;
            exp_we[n]   = we;
            exp_addr[n] = dst;
            exp_data[n] = val;
            pc = pc + 32'd4;
        end
    endtask

    // ==================================================================
    // Per-cycle checks, sampled at the falling edge
    // ==================================================================
    task automatic check_cycle();
        if (acc == 0 || cyc < first_acc + 3) begin
            assert (!rt_valid && !rfw.we)
                else abort_run("Retire port became active before any instruction could retire");
        end
        assert (iaddr == exp_pc[acc]) else value_error("iaddr", iaddr, exp_pc[acc]);
        assert (acc - ret <= 3) else abort_run("More than three instructions are in flight");
        if (rt_valid) begin
            assert (ret < acc) else abort_run("An instruction retired that was never fetched");
            assert (rt_pc == exp_pc[ret]) else value_error("rt_pc", rt_pc, exp_pc[ret]);
            assert (rfw.we == exp_we[ret])
                else value_error("rfw.we", 32'(rfw.we), 32'(exp_we[ret]));
            if (exp_we[ret]) begin
                assert (rfw.addr == exp_addr[ret])
                    else value_error("rfw.addr", 32'(rfw.addr), 32'(exp_addr[ret]));
                assert (rfw.data == exp_data[ret])
                    else value_error("rfw.data", rfw.data, exp_data[ret]);
            end
            if (!freeze) begin
                ret++;  // Leaves rreg on the next edge
            end
        end else begin
            assert (!rfw.we) else abort_run("Register write seen without a retiring instruction");
        end
        if (ihit && !freeze) begin
            if (acc == 0) begin
                first_acc = cyc;
            end
            acc++;
        end
        cyc++;
    endtask

    initial begin
        void'($urandom(32'h72f5_85a5));
        build_program();
        ihit   <= 1'b0;
        freeze <= 1'b0;
        while (cyc < N_CYCLES) begin
            @(posedge clk);
            ihit   <= ($urandom % 4) != 0;
            freeze <= ($urandom % 8) == 0;
            @(negedge clk);
            if (!rst) begin
                check_cycle();
            end
        end
        if (acc - ret <= 3 && ret >= MIN_RET) begin
            $display("Retired %0d of %0d accepted instructions", ret, acc);
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d accepted instructions retired", ret, acc));
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
mips_pkg.sv
reg_read_if.sv
fetch.sv
stage_reg.sv
decode.sv
bypass.sv
execute.sv
regfile.sv
datapath.sv
tb_clock.sv
datapath_assertions.sv
datapath_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --assert -j 0
TOP      := datapath_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
PASS_MSG := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
